// File: dv/ctn_checker.sv
// Assertions on the CTN response port, bound into every ctn_top instance
`timescale 1ns/1ns
`default_nettype none

module ctn_checker
  import ctn_pkg::*;
(
  input logic             clk_aon,
  input logic             rst_n_i,
  input logic             req_i,
  input logic             rsp_valid_o,
  input logic             rsp_err_o,
  input logic [CtnDw-1:0] rsp_rdata_o
);

  int assert_errors = 0;

  // One response per request at a fixed latency
  a_latency : assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    rsp_valid_o == $past(req_i, CtnLatency))
    else begin
      $error("response valid does not follow request by fixed latency");
      assert_errors++;
    end

  a_err_zero : assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    rsp_err_o |-> rsp_rdata_o == '0)
    else begin
      $error("error response carries nonzero data");
      assert_errors++;
    end

  a_known : assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    rsp_valid_o |-> !$isunknown({rsp_err_o, rsp_rdata_o}))
    else begin
      $error("unknown value on a valid response");
      assert_errors++;
    end

endmodule

bind ctn_top ctn_checker i_checker (.*);

`default_nettype wire

// File: dv/ctn_clk_gen.sv
// Free-running clk_aon source for the CTN testbench
`timescale 1ns/1ns
`default_nettype none

module ctn_clk_gen #(
  parameter int PeriodNs = 40
) (
  output logic clk_o
);

  initial clk_o = 1'b0;

  always #(PeriodNs / 2) clk_o = ~clk_o;  // 50 % duty

endmodule

`default_nettype wire

// File: dv/ctn_monitor.sv
// Response monitor for the CTN port. The testbench queues one expected response
// per request; each response is checked for value and arrival cycle.
`timescale 1ns/1ns
`default_nettype none

module ctn_monitor
  import ctn_pkg::*;
(
  input  logic             clk_aon,
  input  logic             rsp_valid_i,
  input  logic             rsp_err_i,
  input  logic [CtnDw-1:0] rsp_rdata_i
);

  // Pipeline registers after the drive edge, then the falling edge that follows
  localparam int SampleDly = CtnLatency + 1;

  logic             exp_err_q [$];
  logic [CtnDw-1:0] exp_rdata_q [$];
  int               exp_cyc_q [$];
  int               cyc = 0;
  int               value_errors = 0;
  int               protocol_errors = 0;

  // Called by the testbench on the edge that drives the request
  task automatic expect_rsp(input logic err, input logic [CtnDw-1:0] rdata);
    exp_err_q.push_back(err);
    exp_rdata_q.push_back(rdata);
    exp_cyc_q.push_back(cyc);
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk_aon) begin
    logic             err;
    logic [CtnDw-1:0] rdata;
    int               due;
    cyc = cyc + 1;
    if (rsp_valid_i === 1'b1) begin
      if (exp_err_q.size() == 0) begin
        $display("Response seen at cycle %0d with no request outstanding", cyc);
        protocol_errors++;
      end else begin
        err   = exp_err_q.pop_front();
        rdata = exp_rdata_q.pop_front();
        due   = exp_cyc_q.pop_front() + SampleDly;
        if (cyc != due) begin
          $display("Response arrived at cycle %0d, expected at cycle %0d", cyc, due);
          protocol_errors++;
        end
        if (rsp_err_i !== err) begin
          $display("[ERROR] rsp_err_o got 0x%0h expected 0x%0h", rsp_err_i, err);
          value_errors++;
        end
        if (rsp_rdata_i !== rdata) begin
          $display("[ERROR] rsp_rdata_o got 0x%08h expected 0x%08h", rsp_rdata_i, rdata);
          value_errors++;
        end
      end
    end else if (rsp_valid_i !== 1'b0) begin
      $display("Response valid is unknown at cycle %0d", cyc);
      protocol_errors++;
    end
  end

endmodule

`default_nettype wire

// File: dv/ctn_tb.sv
// Testbench top for the CTN memory port. Drives directed and LCG-random requests,
// predicts each response with a byte-masked memory model and hands it to the monitor.
`timescale 1ns/1ns
`default_nettype none

module ctn_tb;
  import ctn_pkg::*;

  localparam logic [CtnAw-1:0] RamBase = 32'h0004_0000;
  localparam logic [CtnAw-1:0] MissFlip = 32'h0010_0000;  // Lands outside the window

  // Four tests of 8, 24, 12 and 40 requests
  localparam int NumRequests = 84;
  localparam int CycleLimit  = 4 * NumRequests + 50;

  logic                clk_aon;
  logic                rst_n_i;
  logic                req_i;
  logic                we_i;
  logic [CtnAw-1:0]    addr_i;
  logic [CtnDw-1:0]    wdata_i;
  logic [CtnMaskW-1:0] wmask_i;
  logic                rsp_valid_o;
  logic [CtnDw-1:0]    rsp_rdata_o;
  logic                rsp_err_o;

  logic [CtnDw-1:0] model_mem [CtnRamDepth];
  logic             model_written [CtnRamDepth];
  logic [31:0]      lcg_state = 32'd40;
  int               cycles = 0;

  ctn_clk_gen #(.PeriodNs(40)) i_clk (.clk_o(clk_aon));

  ctn_top #(
    .RamBaseAddr (RamBase)
  ) i_dut (
    .clk_aon     (clk_aon),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .wmask_i     (wmask_i),
    .rsp_valid_o (rsp_valid_o),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_err_o   (rsp_err_o)
  );

  ctn_monitor i_mon (
    .clk_aon     (clk_aon),
    .rsp_valid_i (rsp_valid_o),
    .rsp_err_i   (rsp_err_o),
    .rsp_rdata_i (rsp_rdata_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Random numbers and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Returns {err, rdata}; writes update the model under the byte mask
  function automatic logic [CtnDw:0] ref_access(input logic we, input logic [CtnAw-1:0] addr,
                                                input logic [CtnDw-1:0] wdata,
                                                input logic [CtnMaskW-1:0] wmask);
    logic [CtnRamAw-1:0] idx;
    idx = addr[CtnRamAw+1:2];
    if (addr[CtnAw-1:CtnRamAw+2] != RamBase[CtnAw-1:CtnRamAw+2]) begin
      return {1'b1, {CtnDw{1'b0}}};  // Misses leave the RAM untouched
    end
    if (!we) begin
      return {1'b0, model_mem[idx]};
    end
    for (int b = 0; b < CtnMaskW; b++) begin
      if (wmask[b]) begin
        model_mem[idx][b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    model_written[idx] = 1'b1;
    return {1'b0, {CtnDw{1'b0}}};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [CtnAw-1:0] hit_addr(input logic [CtnRamAw-1:0] idx);
    return RamBase | {idx, 2'b00};
  endfunction

  task automatic issue(input logic we, input logic [CtnAw-1:0] addr,
                       input logic [CtnDw-1:0] wdata, input logic [CtnMaskW-1:0] wmask);
    logic [CtnDw:0] exp;
    @(posedge clk_aon);
    req_i   <= 1'b1;
    we_i    <= we;
    addr_i  <= addr;
    wdata_i <= wdata;
    wmask_i <= wmask;
    exp = ref_access(we, addr, wdata, wmask);
    i_mon.expect_rsp(exp[CtnDw], exp[CtnDw-1:0]);
  endtask

  // Idle the bus and give outstanding responses a little over the latency to arrive
  task automatic drain();
    int waited;
    waited = 0;
    @(posedge clk_aon);
    req_i <= 1'b0;
    we_i  <= 1'b0;
    while (i_mon.exp_err_q.size() != 0 && waited < CtnLatency + 2) begin
      @(posedge clk_aon);
      waited++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk_aon) begin
    cycles <= cycles + 1;
    if (cycles >= CycleLimit) begin
      $display("Run stopped after %0d cycles without finishing", cycles);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    logic [CtnRamAw-1:0] idx;
    logic [CtnMaskW-1:0] mask;
    logic [31:0]         r;
    int                  total;
    for (int i = 0; i < CtnRamDepth; i++) begin
      model_mem[i]     = '0;
      model_written[i] = 1'b0;
    end
    rst_n_i = 1'b0;
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    wmask_i = '0;
    repeat (3) @(posedge clk_aon);
    rst_n_i <= 1'b1;
    repeat (4) @(posedge clk_aon);  // Quiet bus so the monitor catches any stray response

    // Full write then read back
    for (int i = 0; i < 4; i++) begin
      idx = 8'(i * 37 + 5);
      issue(1'b1, hit_addr(idx), next_rand(), 4'hF);
      issue(1'b0, hit_addr(idx), '0, '0);
    end
    drain();

    // Partial writes over a fully written word
    for (int i = 0; i < 8; i++) begin
      idx = 8'(i + 100);
      issue(1'b1, hit_addr(idx), next_rand(), 4'hF);
      issue(1'b1, hit_addr(idx), next_rand(), 4'(next_rand() >> 7));
    end
    for (int i = 0; i < 8; i++) begin
      issue(1'b0, hit_addr(8'(i + 100)), '0, '0);
    end
    drain();

    // Misses answer with an error and never touch the RAM
    for (int i = 0; i < 4; i++) begin
      idx = 8'(i + 100);
      issue(1'b1, hit_addr(idx) ^ MissFlip, next_rand(), 4'hF);
      issue(1'b0, hit_addr(idx) ^ MissFlip, '0, '0);
      issue(1'b0, hit_addr(idx), '0, '0);
    end
    drain();

    // Mixed back-to-back traffic
    for (int i = 0; i < 40; i++) begin
      r    = next_rand();
      idx  = 8'(r >> 8);
      mask = 4'(r >> 20);
      if (r[3:0] < 4'd3) begin
        issue(r[4], hit_addr(idx) ^ MissFlip, next_rand(), mask);
      end else if (!model_written[idx]) begin
        issue(1'b1, hit_addr(idx), next_rand(), 4'hF);  // First write fills the word
      end else begin
        issue(r[5], hit_addr(idx), next_rand(), mask);
      end
    end
    drain();
    repeat (5) @(posedge clk_aon);

    if (i_mon.exp_err_q.size() != 0) begin
      $display("%0d expected responses never arrived", i_mon.exp_err_q.size());
      i_mon.protocol_errors++;
    end
    total = i_mon.value_errors + i_mon.protocol_errors + i_dut.i_checker.assert_errors;
    $display("Errors: value %0d, protocol %0d, assertion %0d, total %0d",
             i_mon.value_errors, i_mon.protocol_errors, i_dut.i_checker.assert_errors, total);
    if (total == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: files.f
source/ctn_pkg.sv
source/ctn_ram_if.sv
source/ctn_window_decode.sv
source/ctn_ram.sv
source/ctn_rsp_merge.sv
source/ctn_top.sv
dv/ctn_clk_gen.sv
dv/ctn_monitor.sv
dv/ctn_checker.sv
dv/ctn_tb.sv

// File: source/ctn_pkg.sv
// Shared widths, window geometry and the host address view for the CTN memory port.
// Imported by every CTN module that needs a width or the decoded address.
`default_nettype none

package ctn_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus and memory geometry
  //////////////////////////////////////////////////////////////////////

  localparam int CtnAw       = 32;             // Host byte address
  localparam int CtnDw       = 32;             // Data word
  localparam int CtnMaskW    = CtnDw / 8;      // One enable per byte
  localparam int CtnRamAw    = 8;              // RAM word index
  localparam int CtnRamDepth = 1 << CtnRamAw;  // 256 words, 1 KiB window
  localparam int CtnLatency  = 3;              // Request edge to response valid

  // Byte offset inside a word, and what is left over for the region tag
  localparam int CtnOffW = 2;
  localparam int CtnTagW = CtnAw - CtnRamAw - CtnOffW;

  //////////////////////////////////////////////////////////////////////
  // Host address views
  //////////////////////////////////////////////////////////////////////

  // Field view of one host address, MSB first
  typedef struct packed {
    logic [CtnTagW-1:0]  region;  // Compared against the window base
    logic [CtnRamAw-1:0] idx;     // Word inside the window
    logic [CtnOffW-1:0]  offset;  // Ignored, accesses are whole words
  } ctn_addr_t;

  // Same word, seen raw or split into fields
  typedef union packed {
    logic [CtnAw-1:0] raw;
    ctn_addr_t        f;
  } ctn_addr_u;

endpackage

`default_nettype wire

// File: source/ctn_ram.sv
// Single-port CTN SRAM behind the window decoder.
// Byte-masked writes; reads return the addressed word one cycle after the request.
`timescale 1ns/1ns
`default_nettype none

module ctn_ram
  import ctn_pkg::*;
(
  input  logic             clk_aon,
  input  logic             rst_n_i,

  // Steered request, always granted
  ctn_ram_if.ram           ram,

  // Read data, valid the cycle after a read request
  output logic [CtnDw-1:0] rdata_o
);

  localparam int ByteW = CtnDw / CtnMaskW;

  logic [CtnDw-1:0] mem_q [CtnRamDepth];

  //////////////////////////////////////////////////////////////////////
  // Storage array
  //////////////////////////////////////////////////////////////////////

  // Only the enabled bytes of the word are written
  always_ff @(posedge clk_aon) begin
    if (ram.req && ram.we) begin
      for (int b = 0; b < CtnMaskW; b++) begin
        if (ram.wmask[b]) begin
          mem_q[ram.idx][b*ByteW +: ByteW] <= ram.wdata[b*ByteW +: ByteW];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////////////////////////

  // Holds the last read word; writes leave it alone
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rdata_o <= '0;
    end else if (ram.req && !ram.we) begin
      rdata_o <= mem_q[ram.idx];
    end
  end

endmodule

`default_nettype wire

// File: source/ctn_ram_if.sv
// Steered RAM request between the window decoder and the SRAM.
// Single-cycle strobe, no grant; the RAM takes every cycle where req is high.
`timescale 1ns/1ns
`default_nettype none

interface ctn_ram_if
  import ctn_pkg::*;
();

  logic                req;    // Only window hits ever raise this
  logic                we;
  logic [CtnRamAw-1:0] idx;
  logic [CtnDw-1:0]    wdata;
  logic [CtnMaskW-1:0] wmask;

  // Request side
  modport decoder (
    output req, we, idx, wdata, wmask
  );

  // Memory side
  modport ram (
    input req, we, idx, wdata, wmask
  );

endinterface

`default_nettype wire

// File: source/ctn_rsp_merge.sv
// Response side of the CTN port. Delays the request tag until RAM read data is
// ready, then registers one response per request: read data, zero, or an error.
`timescale 1ns/1ns
`default_nettype none

module ctn_rsp_merge
  import ctn_pkg::*;
(
  input  logic             clk_aon,
  input  logic             rst_n_i,

  // Tag from the window decoder
  input  logic             tag_valid_i,
  input  logic             tag_we_i,
  input  logic             tag_miss_i,

  // Registered RAM read data
  input  logic [CtnDw-1:0] ram_rdata_i,

  // Host response
  output logic             rsp_valid_o,
  output logic             rsp_err_o,
  output logic [CtnDw-1:0] rsp_rdata_o
);

  // Decode stage and output stage take one cycle each, the rest is tag delay
  localparam int TagDly = CtnLatency - 2;

  logic [2:0] tag_in;
  logic [2:0] tag_q [TagDly];
  logic       dly_valid;
  logic       dly_we;
  logic       dly_miss;
  logic       rd_hit;

  assign tag_in = {tag_valid_i, tag_we_i, tag_miss_i};

  //////////////////////////////////////////////////////////////////////
  // Tag delay line
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < TagDly; i++) begin
        tag_q[i] <= '0;
      end
    end else begin
      for (int i = TagDly - 1; i > 0; i--) begin
        tag_q[i] <= tag_q[i-1];
      end
      tag_q[0] <= tag_in;
    end
  end

  assign {dly_valid, dly_we, dly_miss} = tag_q[TagDly-1];  // Lines up with ram_rdata_i
  assign rd_hit = dly_valid & ~dly_we & ~dly_miss;

  //////////////////////////////////////////////////////////////////////
  // Response register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
      rsp_err_o   <= 1'b0;
      rsp_rdata_o <= '0;
    end else begin
      rsp_valid_o <= dly_valid;
      rsp_err_o   <= dly_valid & dly_miss;
      // Writes and misses answer with zero data
      rsp_rdata_o <= rd_hit ? ram_rdata_i : '0;
    end
  end

endmodule

`default_nettype wire

// File: source/ctn_top.sv
// Top level of the CTN memory port: window decoder, SRAM and response merge.
// The host drives plain strobed requests and gets one in-order response each.
`timescale 1ns/1ns
`default_nettype none

module ctn_top
  import ctn_pkg::*;
#(
  parameter logic [CtnAw-1:0] RamBaseAddr = 32'h0004_0000  // 1 KiB aligned
) (
  input  logic                clk_aon,
  input  logic                rst_n_i,

  // Host request
  input  logic                req_i,
  input  logic                we_i,
  input  logic [CtnAw-1:0]    addr_i,
  input  logic [CtnDw-1:0]    wdata_i,
  input  logic [CtnMaskW-1:0] wmask_i,

  // Host response, CtnLatency cycles after the request
  output logic                rsp_valid_o,
  output logic [CtnDw-1:0]    rsp_rdata_o,
  output logic                rsp_err_o
);

  //////////////////////////////////////////////////////////////////////
  // Internal connections
  //////////////////////////////////////////////////////////////////////

  ctn_ram_if u_ram_if ();

  logic             tag_valid;
  logic             tag_we;
  logic             tag_miss;
  logic [CtnDw-1:0] ram_rdata;

  //////////////////////////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////////////////////////

  ctn_window_decode #(
    .RamBaseAddr (RamBaseAddr)
  ) u_window_decode (
    .clk_aon     (clk_aon),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .wmask_i     (wmask_i),
    .ram         (u_ram_if.decoder),
    .tag_valid_o (tag_valid),
    .tag_we_o    (tag_we),
    .tag_miss_o  (tag_miss)
  );

  ctn_ram u_ram (
    .clk_aon (clk_aon),
    .rst_n_i (rst_n_i),
    .ram     (u_ram_if.ram),
    .rdata_o (ram_rdata)
  );

  ctn_rsp_merge u_rsp_merge (
    .clk_aon     (clk_aon),
    .rst_n_i     (rst_n_i),
    .tag_valid_i (tag_valid),
    .tag_we_i    (tag_we),
    .tag_miss_i  (tag_miss),
    .ram_rdata_i (ram_rdata),
    .rsp_valid_o (rsp_valid_o),
    .rsp_err_o   (rsp_err_o),
    .rsp_rdata_o (rsp_rdata_o)
  );

endmodule

`default_nettype wire

// File: source/ctn_window_decode.sv
// Input stage of the CTN port. Registers each host request, checks it against the
// RAM window and sends hits to the SRAM; every request also leaves a response tag.
`timescale 1ns/1ns
`default_nettype none

module ctn_window_decode
  import ctn_pkg::*;
#(
  parameter logic [CtnAw-1:0] RamBaseAddr = 32'h0004_0000
) (
  input  logic                clk_aon,
  input  logic                rst_n_i,

  // Host request
  input  logic                req_i,
  input  logic                we_i,
  input  ctn_addr_u           addr_i,
  input  logic [CtnDw-1:0]    wdata_i,
  input  logic [CtnMaskW-1:0] wmask_i,

  // Steered request towards the SRAM
  ctn_ram_if.decoder          ram,

  // Response tag, one per accepted request
  output logic                tag_valid_o,
  output logic                tag_we_o,
  output logic                tag_miss_o
);

  //////////////////////////////////////////////////////////////////////
  // Window check
  //////////////////////////////////////////////////////////////////////

  // Base must sit on a window boundary, so only the region tag matters
  localparam ctn_addr_u BaseAddr = RamBaseAddr;

  logic hit;

  assign hit = (addr_i.f.region == BaseAddr.f.region);

  //////////////////////////////////////////////////////////////////////
  // Request stage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ram.req     <= 1'b0;
      tag_valid_o <= 1'b0;
      tag_we_o    <= 1'b0;
      tag_miss_o  <= 1'b0;
    end else begin
      ram.req     <= req_i & hit;   // Misses never reach the RAM
      tag_valid_o <= req_i;
      tag_we_o    <= req_i & we_i;
      tag_miss_o  <= req_i & ~hit;  // Turned into an error response later
    end
  end

  // Payload only moves when a hit is steered to the RAM
  always_ff @(posedge clk_aon) begin
    if (req_i && hit) begin
      ram.we    <= we_i;
      ram.idx   <= addr_i.f.idx;
      ram.wdata <= wdata_i;
      ram.wmask <= wmask_i;
    end
  end

endmodule

`default_nettype wire
